// File: soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define ADDR_W 16
`define DATA_W 32

// Slaves and the region field in the top address bits
`define N_SLAVES 4
`define SEL_W 2

// Byte address widths of the two RAMs
`define BOOT_ADDR_W 8
`define RAM_ADDR_W 10

// Clock cycles per serial bit
`define UART_DIV 4

`endif

// File: soc_map_pkg.sv
`include "soc_defines.svh"

package soc_map_pkg;

   // Bus vectors
   typedef logic [`ADDR_W-1:0] addr_t;
   typedef logic [`DATA_W-1:0] word_t;

   // One strobe per byte lane, all zeros is a read
   typedef logic [`DATA_W/8-1:0] wstrb_t;

   // Regions of the address space, taken from the top address bits
   typedef enum logic [`SEL_W-1:0] {
      SLV_BOOT = 2'd0,
      SLV_RAM  = 2'd1,
      SLV_UART = 2'd2,
      SLV_SRST = 2'd3
   } slave_idx_t;

endpackage

// File: uart_pkg.sv
package uart_pkg;

   // One serial character
   typedef logic [7:0] uart_byte_t;

   // Transmitter frame phases
   typedef enum logic [1:0] {
      IDLE,
      START,
      DATA,
      STOP
   } uart_state_t;

endpackage

// File: slave_bus_if.sv
`timescale 1ns/1ps

interface slave_bus_if;
   import soc_map_pkg::*;

   // Request side, driven by the decoder
   logic   valid;
   addr_t  addr;
   word_t  wdata;
   wstrb_t wstrb;

   // Response side, driven by the slave
   logic   ready;
   word_t  rdata;

   modport master (
      output valid,
      output addr,
      output wdata,
      output wstrb,
      input  ready,
      input  rdata
   );

   modport slave (
      input  valid,
      input  addr,
      input  wdata,
      input  wstrb,
      output ready,
      output rdata
   );

   // Return path only needs the handshake and the data
   modport monitor (
      input valid,
      input ready,
      input rdata
   );

endinterface

// File: bus_decoder.sv
`timescale 1ns/1ps

`include "soc_defines.svh"

module bus_decoder (
   input  logic               mem_valid,
   input  soc_map_pkg::addr_t  mem_addr,
   input  soc_map_pkg::word_t  mem_wdata,
   input  soc_map_pkg::wstrb_t mem_wstrb,
   input  logic               boot,
   slave_bus_if.master        s_boot,
   slave_bus_if.master        s_ram,
   slave_bus_if.master        s_uart,
   slave_bus_if.master        s_srst
);
   import soc_map_pkg::*;

   slave_idx_t          region;
   logic [`N_SLAVES-1:0] sel_valid;

   always_comb begin
      region = slave_idx_t'(mem_addr[`ADDR_W-1 -: `SEL_W]);
      // Region 0 lands on main memory once boot is done
      if (!boot && region == SLV_BOOT) begin
         region = SLV_RAM;
      end
      sel_valid = '0;
      sel_valid[region] = mem_valid;
   end

   assign s_boot.valid = sel_valid[SLV_BOOT];
   assign s_ram.valid  = sel_valid[SLV_RAM];
   assign s_uart.valid = sel_valid[SLV_UART];
   assign s_srst.valid = sel_valid[SLV_SRST];

   // Request payload goes to every port, only valid is steered
   assign s_boot.addr  = mem_addr;
   assign s_boot.wdata = mem_wdata;
   assign s_boot.wstrb = mem_wstrb;

   assign s_ram.addr   = mem_addr;
   assign s_ram.wdata  = mem_wdata;
   assign s_ram.wstrb  = mem_wstrb;

   assign s_uart.addr  = mem_addr;
   assign s_uart.wdata = mem_wdata;
   assign s_uart.wstrb = mem_wstrb;

   assign s_srst.addr  = mem_addr;
   assign s_srst.wdata = mem_wdata;
   assign s_srst.wstrb = mem_wstrb;

endmodule

// File: word_ram.sv
`timescale 1ns/1ps

module word_ram #(
   parameter int AWORD = 6
) (
   input  logic       clk,
   input  logic       reset,
   slave_bus_if.slave bus
);
   import soc_map_pkg::*;

   word_t            mem [2**AWORD];
   word_t            rdata_q;
   logic             ready_q;
   logic             accept;
   logic [AWORD-1:0] widx;

   // Byte address bits 1:0 select a lane, not a word
   assign widx = bus.addr[AWORD+1:2];

   // One access per request, the held valid does not retrigger
   assign accept = bus.valid && !ready_q;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         for (int b = 0; b < $bits(wstrb_t); b++) begin
            if (bus.wstrb[b]) begin
               mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
         end
         // Old contents on a write, nobody looks at it then
         rdata_q <= mem[widx];
      end
   end

   assign bus.ready = ready_q;
   assign bus.rdata = rdata_q;

endmodule

// File: reset_ctrl.sv
`timescale 1ns/1ps

module reset_ctrl (
   input  logic       clk,
   input  logic       reset,
   slave_bus_if.slave bus,
   output logic       boot,
   output logic       cpu_reset
);

   logic ready_q;
   logic soft_reset;
   logic accept;
   logic is_write;

   assign accept   = bus.valid && !ready_q;
   assign is_write = bus.wstrb != '0;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q    <= 1'b0;
         soft_reset <= 1'b0;
         boot       <= 1'b1;
      end else begin
         ready_q    <= accept;
         // Pulse lines up with the ready of the write
         soft_reset <= accept && is_write;
         // Flag drops the cycle after the pulse and stays down
         if (soft_reset) begin
            boot <= 1'b0;
         end
      end
   end

   assign bus.ready = ready_q;

   // Register has nothing to read back
   assign bus.rdata = '0;

   assign cpu_reset = reset | soft_reset;

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

`include "soc_defines.svh"

module uart_tx (
   input  logic       clk,
   input  logic       reset,
   slave_bus_if.slave bus,
   output logic       txd
);
   import uart_pkg::*;

   uart_state_t                   state;
   uart_byte_t                    shift;
   logic [$clog2(`UART_DIV)-1:0]  div_cnt;
   logic [2:0]                    bit_cnt;
   logic                          ready_q;
   logic                          is_write;
   logic                          busy;
   logic                          bit_end;
   logic                          accept;
   logic                          load;

   assign is_write = bus.wstrb != '0;
   assign busy     = state != IDLE;
   assign bit_end  = div_cnt == `UART_DIV - 1;

   // Status reads always go through, writes wait for IDLE
   assign accept = bus.valid && !ready_q && (!is_write || !busy);
   assign load   = accept && is_write;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
         state   <= IDLE;
         div_cnt <= '0;
         bit_cnt <= '0;
         txd     <= 1'b1;
      end else begin
         ready_q <= accept;

         // Line follows the state one cycle late
         case (state)
            START:   txd <= 1'b0;
            DATA:    txd <= shift[0];
            default: txd <= 1'b1;
         endcase

         if (state == IDLE) begin
            div_cnt <= '0;
         end else if (bit_end) begin
            div_cnt <= '0;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end

         case (state)
            IDLE: begin
               if (load) begin
                  state <= START;
               end
            end
            START: begin
               if (bit_end) begin
                  state   <= DATA;
                  bit_cnt <= '0;
               end
            end
            DATA: begin
               if (bit_end) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) begin
                     state <= STOP;
                  end
               end
            end
            STOP: begin
               if (bit_end) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // LSB first, next bit moves to position 0 at each bit end
   always_ff @(posedge clk) begin
      if (load) begin
         shift <= bus.wdata[7:0];
      end else if (state == DATA && bit_end) begin
         shift <= shift >> 1;
      end
   end

   assign bus.ready = ready_q;
   assign bus.rdata = {{(`DATA_W-1){1'b0}}, busy};

endmodule

// File: read_return.sv
`timescale 1ns/1ps

module read_return (
   slave_bus_if.monitor       m_boot,
   slave_bus_if.monitor       m_ram,
   slave_bus_if.monitor       m_uart,
   slave_bus_if.monitor       m_srst,
   output soc_map_pkg::word_t mem_rdata,
   output logic               mem_ready
);

   // At most one valid is high, the decoder makes sure of that
   always_comb begin
      mem_rdata = '0;
      mem_ready = 1'b0;
      if (m_boot.valid) begin
         mem_rdata = m_boot.rdata;
         mem_ready = m_boot.ready;
      end else if (m_ram.valid) begin
         mem_rdata = m_ram.rdata;
         mem_ready = m_ram.ready;
      end else if (m_uart.valid) begin
         mem_rdata = m_uart.rdata;
         mem_ready = m_uart.ready;
      end else if (m_srst.valid) begin
         mem_rdata = m_srst.rdata;
         mem_ready = m_srst.ready;
      end
   end

endmodule

// File: soc_bus_system.sv
`timescale 1ns/1ps

`include "soc_defines.svh"

module soc_bus_system (
   input  logic                clk,
   input  logic                reset,

   // Master memory port
   input  logic                mem_valid,
   input  soc_map_pkg::addr_t  mem_addr,
   input  soc_map_pkg::word_t  mem_wdata,
   input  soc_map_pkg::wstrb_t mem_wstrb,
   output soc_map_pkg::word_t  mem_rdata,
   output logic                mem_ready,

   // Serial line
   output logic                uart_txd,

   // Reset for the CPU
   output logic                cpu_reset
);

   logic boot;

   slave_bus_if bus_boot ();
   slave_bus_if bus_ram ();
   slave_bus_if bus_uart ();
   slave_bus_if bus_srst ();

   bus_decoder u_decoder (
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .boot      (boot),
      .s_boot    (bus_boot.master),
      .s_ram     (bus_ram.master),
      .s_uart    (bus_uart.master),
      .s_srst    (bus_srst.master)
   );

   // Word address width is the byte width less the lane bits
   word_ram #(
      .AWORD (`BOOT_ADDR_W - 2)
   ) u_boot_ram (
      .clk   (clk),
      .reset (reset),
      .bus   (bus_boot.slave)
   );

   word_ram #(
      .AWORD (`RAM_ADDR_W - 2)
   ) u_main_ram (
      .clk   (clk),
      .reset (reset),
      .bus   (bus_ram.slave)
   );

   uart_tx u_uart (
      .clk   (clk),
      .reset (reset),
      .bus   (bus_uart.slave),
      .txd   (uart_txd)
   );

   reset_ctrl u_reset_ctrl (
      .clk       (clk),
      .reset     (reset),
      .bus       (bus_srst.slave),
      .boot      (boot),
      .cpu_reset (cpu_reset)
   );

   read_return u_return (
      .m_boot    (bus_boot.monitor),
      .m_ram     (bus_ram.monitor),
      .m_uart    (bus_uart.monitor),
      .m_srst    (bus_srst.monitor),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

endmodule

// File: soc_bus_sva.sv
`timescale 1ns/1ps

module soc_bus_sva (
   input logic clk,
   input logic reset,
   input logic mem_ready,
   input logic cpu_reset,
   input logic uart_txd,
   input logic uart_busy
);

   // Number of failed assertions
   int fail_count = 0;

   // One ready pulse per request
   property p_ready_single;
      @(posedge clk) disable iff (reset)
         mem_ready |=> !mem_ready;
   endproperty

   // Soft reset is a single-cycle pulse
   property p_cpu_reset_pulse;
      @(posedge clk) disable iff (reset)
         cpu_reset |=> !cpu_reset;
   endproperty

   // Line rests high between frames
   property p_txd_idle_high;
      @(posedge clk) disable iff (reset)
         !uart_busy |-> uart_txd;
   endproperty

   a_ready_single: assert property (p_ready_single)
      else begin
         $error("mem_ready high for two cycles in a row");
         fail_count++;
      end

   a_cpu_reset_pulse: assert property (p_cpu_reset_pulse)
      else begin
         $error("cpu_reset high for more than one cycle");
         fail_count++;
      end

   a_txd_idle_high: assert property (p_txd_idle_high)
      else begin
         $error("uart_txd low while the transmitter is idle");
         fail_count++;
      end

endmodule

bind soc_bus_system soc_bus_sva u_sva (
   .clk       (clk),
   .reset     (reset),
   .mem_ready (mem_ready),
   .cpu_reset (cpu_reset),
   .uart_txd  (uart_txd),
   .uart_busy (bus_uart.rdata[0])
);

// File: tb_soc_bus.sv
`timescale 1ns/1ps

`include "soc_defines.svh"

module tb_soc_bus;
   import soc_map_pkg::*;
   import uart_pkg::*;

   localparam int TIMEOUT       = 100;
   localparam int START_TIMEOUT = 20;
   localparam int FRAME_CYCLES  = 10 * `UART_DIV;

   typedef enum logic [2:0] {
      OP_WRITE,
      OP_READ,
      OP_UART_WR,
      OP_UART_STAT,
      OP_SRST
   } op_kind_t;

   // busy marks a held-off UART write or the expected status bit
   typedef struct packed {
      op_kind_t kind;
      addr_t    addr;
      word_t    data;
      wstrb_t   strb;
      word_t    exp;
      logic     busy;
   } op_t;

   logic   clk;
   logic   reset;
   logic   mem_valid;
   addr_t  mem_addr;
   word_t  mem_wdata;
   wstrb_t mem_wstrb;
   word_t  mem_rdata;
   logic   mem_ready;
   logic   uart_txd;
   logic   cpu_reset;

   op_t        ops[$];
   uart_byte_t exp_bytes[$];
   word_t      boot_model [2**(`BOOT_ADDR_W-2)];
   word_t      main_model [2**(`RAM_ADDR_W-2)];
   logic       model_boot;
   word_t      rng;
   int         cycle_no        = 0;
   int         frames_sent     = 0;
   int         frames_done     = 0;
   int         last_uart_ready = 0;

   soc_bus_system u_dut (
      .clk       (clk),
      .reset     (reset),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready),
      .uart_txd  (uart_txd),
      .cpu_reset (cpu_reset)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_no <= cycle_no + 1;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   // Any failed assertion in the bound checker ends the run
   always @(u_dut.u_sva.fail_count) begin
      if (u_dut.u_sva.fail_count != 0) begin
         fail_run("Assertion failed in the bus checker");
      end
   end

   task automatic check_word(input string name, input word_t exp, input word_t got);
      if (got !== exp) begin
         fail_run($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, got));
      end
   endtask

   task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t got);
      if (got !== exp) begin
         fail_run($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, got));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         fail_run($sformatf("FAIL t=%0t %s expected %b got %b", $time, name, exp, got));
      end
   endtask

   task automatic check_latency(input string name, input int lo, input int hi, input int got);
      if (got < lo || got > hi) begin
         fail_run($sformatf("FAIL t=%0t %s expected %0d..%0d got %0d",
                            $time, name, lo, hi, got));
      end
   endtask

   function automatic word_t xorshift32(input word_t x);
      word_t y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic word_t rand_word();
      rng = xorshift32(rng);
      return rng;
   endfunction

   function automatic word_t merge_bytes(input word_t old, input word_t wr, input wstrb_t strb);
      word_t w;
      w = old;
      for (int b = 0; b < $bits(wstrb_t); b++) begin
         if (strb[b]) begin
            w[8*b +: 8] = wr[8*b +: 8];
         end
      end
      return w;
   endfunction

   // Expected values come from the model as the table grows
   task automatic add_op(input op_kind_t kind, input addr_t addr, input word_t data,
                         input wstrb_t strb, input logic busy);
      op_t        op;
      logic [1:0] region;
      region  = addr[`ADDR_W-1 -: `SEL_W];
      op.kind = kind;
      op.addr = addr;
      op.data = data;
      op.strb = strb;
      op.busy = busy;
      op.exp  = '0;
      case (kind)
         OP_WRITE: begin
            if (region == 2'd0 && model_boot) begin
               boot_model[addr[`BOOT_ADDR_W-1:2]] =
                  merge_bytes(boot_model[addr[`BOOT_ADDR_W-1:2]], data, strb);
            end else begin
               main_model[addr[`RAM_ADDR_W-1:2]] =
                  merge_bytes(main_model[addr[`RAM_ADDR_W-1:2]], data, strb);
            end
         end
         OP_READ: begin
            if (region == 2'd3) begin
               op.exp = '0;
            end else if (region == 2'd0 && model_boot) begin
               op.exp = boot_model[addr[`BOOT_ADDR_W-1:2]];
            end else begin
               op.exp = main_model[addr[`RAM_ADDR_W-1:2]];
            end
         end
         OP_UART_STAT: op.exp = word_t'(busy);
         OP_SRST:      model_boot = 1'b0;
         default:      ;
      endcase
      ops.push_back(op);
   endtask

   task automatic build_table();
      for (int i = 0; i < 4; i++) begin
         add_op(OP_WRITE, addr_t'(16'h4000 + 4*i), rand_word(), 4'hF, 1'b0);
      end
      // Same offsets in region 0 go to the boot RAM
      for (int i = 0; i < 4; i++) begin
         add_op(OP_WRITE, addr_t'(4*i), rand_word(), 4'hF, 1'b0);
      end
      for (int i = 0; i < 4; i++) begin
         add_op(OP_READ, addr_t'(4*i), '0, '0, 1'b0);
      end
      for (int i = 0; i < 4; i++) begin
         add_op(OP_READ, addr_t'(16'h4000 + 4*i), '0, '0, 1'b0);
      end
      // Partial writes on top of the full words
      add_op(OP_WRITE, 16'h4000, rand_word(), 4'b0001, 1'b0);
      add_op(OP_WRITE, 16'h4004, rand_word(), 4'b0110, 1'b0);
      add_op(OP_WRITE, 16'h4008, rand_word(), 4'b1000, 1'b0);
      add_op(OP_WRITE, 16'h400C, rand_word(), 4'b1010, 1'b0);
      for (int i = 0; i < 4; i++) begin
         add_op(OP_READ, addr_t'(16'h4000 + 4*i), '0, '0, 1'b0);
      end
      add_op(OP_SRST, 16'hC000, rand_word(), 4'hF, 1'b0);
      add_op(OP_READ, 16'hC004, '0, '0, 1'b0);
      // Region 0 now shows main memory
      for (int i = 0; i < 4; i++) begin
         add_op(OP_READ, addr_t'(4*i), '0, '0, 1'b0);
      end
      add_op(OP_UART_WR, 16'h8000, rand_word(), 4'h1, 1'b0);
      add_op(OP_UART_STAT, 16'h8000, '0, '0, 1'b1);
      add_op(OP_UART_STAT, 16'h8000, '0, '0, 1'b0);
      // Second of two back to back writes is held off
      add_op(OP_UART_WR, 16'h8000, rand_word(), 4'h1, 1'b0);
      add_op(OP_UART_WR, 16'h8000, rand_word(), 4'h1, 1'b1);
      add_op(OP_UART_STAT, 16'h8000, '0, '0, 1'b1);
      add_op(OP_UART_STAT, 16'h8000, '0, '0, 1'b0);
   endtask

   // Master model that samples outputs at the falling edge
   task automatic bus_access(input addr_t addr, input word_t wdata, input wstrb_t strb,
                             output word_t rdata, output int lat, output logic rst_seen,
                             output int rdy_cycle);
      int   waited;
      logic got_ready;
      @(posedge clk);
      #1;
      mem_valid = 1'b1;
      mem_addr  = addr;
      mem_wdata = wdata;
      mem_wstrb = strb;
      waited    = 0;
      got_ready = 1'b0;
      while (!got_ready) begin
         @(negedge clk);
         if (mem_ready === 1'b1) begin
            got_ready = 1'b1;
         end else if (waited >= TIMEOUT) begin
            fail_run($sformatf("Timeout waiting for mem_ready at address %h", addr));
         end else begin
            @(posedge clk);
            waited++;
         end
      end
      rdata     = mem_rdata;
      lat       = waited;
      rst_seen  = cpu_reset;
      rdy_cycle = cycle_no;
      @(posedge clk);
      #1;
      mem_valid = 1'b0;
      mem_wstrb = '0;
   endtask

   task automatic wait_frames_done();
      int waited;
      waited = 0;
      while (frames_done != frames_sent) begin
         @(negedge clk);
         waited++;
         if (waited >= 2*FRAME_CYCLES + TIMEOUT) begin
            fail_run("Timeout waiting for a serial frame to finish");
         end
      end
   endtask

   task automatic run_op(input op_t op);
      word_t rdata;
      int    lat;
      logic  rst_seen;
      int    rdy_cycle;
      case (op.kind)
         OP_SRST: begin
            check_bit("cpu_reset", 1'b0, cpu_reset);
            bus_access(op.addr, op.data, op.strb, rdata, lat, rst_seen, rdy_cycle);
            check_bit("cpu_reset", 1'b1, rst_seen);
            check_bit("cpu_reset", 1'b0, cpu_reset);
            check_latency("soft reset ready", 1, 1, lat);
         end
         OP_UART_WR: begin
            exp_bytes.push_back(op.data[7:0]);
            frames_sent++;
            bus_access(op.addr, op.data, op.strb, rdata, lat, rst_seen, rdy_cycle);
            if (op.busy) begin
               check_latency("held uart write ready gap", FRAME_CYCLES, FRAME_CYCLES + 2,
                             rdy_cycle - last_uart_ready);
            end else begin
               check_latency("uart write ready", 1, 1, lat);
            end
            last_uart_ready = rdy_cycle;
         end
         OP_UART_STAT: begin
            if (!op.busy) begin
               wait_frames_done();
            end
            bus_access(op.addr, op.data, op.strb, rdata, lat, rst_seen, rdy_cycle);
            check_bit("uart busy", op.busy, rdata[0]);
            check_word("mem_rdata", op.exp, rdata);
            check_latency("uart status ready", 1, 1, lat);
         end
         default: begin
            bus_access(op.addr, op.data, op.strb, rdata, lat, rst_seen, rdy_cycle);
            if (op.kind == OP_READ) begin
               check_word("mem_rdata", op.exp, rdata);
            end
            check_latency("ram ready", 1, 1, lat);
         end
      endcase
   endtask

   // Samples each bit near its middle once the start bit is seen
   task automatic receive_frame();
      uart_byte_t got;
      uart_byte_t exp;
      repeat (`UART_DIV / 2) @(negedge clk);
      check_bit("uart_txd", 1'b0, uart_txd);
      for (int i = 0; i < 8; i++) begin
         repeat (`UART_DIV) @(negedge clk);
         got[i] = uart_txd;
      end
      repeat (`UART_DIV) @(negedge clk);
      check_bit("uart_txd", 1'b1, uart_txd);
      exp = exp_bytes.pop_front();
      check_byte("uart byte", exp, got);
      repeat (`UART_DIV / 2) @(negedge clk);
      frames_done++;
   endtask

   initial begin : serial_checker
      int idle;
      idle = 0;
      forever begin
         @(negedge clk);
         if (reset !== 1'b0) begin
            idle = 0;
         end else if (uart_txd === 1'b0) begin
            if (exp_bytes.size() == 0) begin
               fail_run("Start bit on uart_txd with no byte written");
            end
            receive_frame();
            idle = 0;
         end else if (exp_bytes.size() != 0) begin
            idle++;
            if (idle > START_TIMEOUT) begin
               fail_run("Timeout waiting for the uart start bit");
            end
         end
      end
   end

   initial begin
      mem_valid  = 1'b0;
      mem_addr   = '0;
      mem_wdata  = '0;
      mem_wstrb  = '0;
      reset      = 1'b1;
      rng        = 32'd81002;
      model_boot = 1'b1;
      build_table();
      repeat (3) @(posedge clk);
      #1;
      check_bit("cpu_reset", 1'b1, cpu_reset);
      check_bit("mem_ready", 1'b0, mem_ready);
      check_bit("uart_txd", 1'b1, uart_txd);
      reset = 1'b0;
      #1;
      check_bit("cpu_reset", 1'b0, cpu_reset);
      for (int i = 0; i < ops.size(); i++) begin
         run_op(ops[i]);
      end
      wait_frames_done();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: tb.f
+incdir+.
soc_map_pkg.sv
uart_pkg.sv
slave_bus_if.sv
bus_decoder.sv
word_ram.sv
reset_ctrl.sv
uart_tx.sv
read_return.sv
soc_bus_system.sv
soc_bus_sva.sv
tb_soc_bus.sv
